/* list.f */
source/motor_ctrl_pkg.sv
source/fault_monitor.sv
source/control_registers.sv
source/current_pi_controller.sv
source/voltage_arbiter.sv
source/motor_control_top.sv
tb/motor_control_checker.sv
tb/tb_motor_control.sv

/* run.sh */
#!/bin/sh
# Build and run the motor control testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_motor_control -o sim_motor_control
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_motor_control)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

/* tb/tb_motor_control.sv */
// Random traffic from a fixed seed; fault events are applied only with all pipelines drained.
`timescale 1ns/1ps

module tb_motor_control;
    import motor_ctrl_pkg::*;

    localparam int gain_scale  = 8;
    localparam int num_trans   = 600;           // Rough count of host and stream transfers.
    localparam int cycle_limit = 8 * num_trans; // Generous bound on the whole run.

    logic               clk = 1'b0;
    logic               reset;
    logic [4:0]         address;
    logic               read;
    logic               write;
    logic [15:0]        writedata;
    logic [15:0]        readdata;
    fault_status_t      status;
    logic [3:0]         pos_error;
    logic [3:0]         pos_uncertain;
    logic signed [15:0] encoder_count [num_axes];
    logic [num_axes-1:0] meas_valid;
    logic [num_axes-1:0] meas_ready;
    dq_pair_t           meas [num_axes];
    logic               out_valid;
    logic               out_ready;
    voltage_cmd_t       out_cmd;
    logic               fault;
    logic               irq;
    int                 errors;     // From the checker.
    int                 pending;    // Commands still in flight.
    int                 tb_errors = 0;
    int                 cycles = 0;

    always #20 clk = ~clk; // 40 ns period.

    motor_control_top #(.gain_scale(gain_scale)) dut (.*);

    motor_control_checker #(.gain_scale(gain_scale)) u_checker (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic host_access(input logic [4:0] a, input logic wr, input logic [15:0] d);
        @(posedge clk);
        address   <= a;
        read      <= !wr;
        write     <= wr;
        writedata <= d;
        @(posedge clk);
        read  <= 1'b0; // One-cycle strobe.
        write <= 1'b0;
    endtask

    function automatic logic [15:0] random_gain();
        return (($urandom % 4) == 0) ? 16'($urandom) : 16'($urandom % 1024); // Mostly small.
    endfunction

    // **************************************************
    // Random host and stream traffic.
    // **************************************************
    task automatic run_traffic(input int n);
        logic [4:0] a;
        repeat (n) begin
            @(posedge clk);
            read      <= 1'b0;
            write     <= 1'b0;
            out_ready <= ($urandom % 10) < 7; // About 70 percent.
            for (int k = 0; k < num_axes; k++) begin
                if (!meas_valid[k] || meas_ready[k]) begin // Hold a stalled offer.
                    meas_valid[k] <= 1'($urandom);
                    meas[k]       <= 32'($urandom);
                end
                if (($urandom % 8) == 0) encoder_count[k] <= 16'($urandom);
            end
            pos_error     <= 4'($urandom);
            pos_uncertain <= 4'($urandom);
            case ($urandom % 4)
                0: begin
                    address <= 5'($urandom);
                    read    <= 1'b1;
                end
                1: begin
                    a = 5'(16 + $urandom % 10); // References and gains only.
                    address   <= a;
                    write     <= 1'b1;
                    writedata <= (a >= 5'd24) ? random_gain() : 16'($urandom);
                end
                default: ;
            endcase
        end
    endtask

    // Stop offering measurements and empty every pipeline.
    task automatic drain();
        do begin
            @(posedge clk);
            read       <= 1'b0;
            write      <= 1'b0;
            out_ready  <= 1'b1;
            meas_valid <= meas_valid & ~meas_ready;
        end while (meas_valid != '0 || pending != 0);
    endtask

    initial begin
        int n;
        int bit_sel;
        void'($urandom(28));
        reset = 1'b1;
        {address, read, write, writedata} = '0;
        status = '1; // No fault condition.
        pos_error = '0;
        pos_uncertain = '0;
        meas_valid = '0;
        out_ready = 1'b0;
        for (int k = 0; k < num_axes; k++) begin
            encoder_count[k] = '0;
            meas[k] = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Register writes, readback, and the unmapped range.
        for (int a = 16; a < 26; a++) begin
            host_access(5'(a), 1'b1, (a >= 24) ? random_gain() : 16'($urandom));
            host_access(5'(a), 1'b0, 16'd0);
        end
        for (int a = 26; a < 32; a++) host_access(5'(a), 1'b0, 16'd0);

        run_traffic(200);
        drain();

        // Output stall: the streams must back up.
        @(posedge clk);
        out_ready  <= 1'b0;
        meas_valid <= '1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (meas_ready != '0 && n < 40);
        if (meas_ready != '0) begin
            tb_errors++;
            $display("meas_ready stayed high while the output was stalled");
        end
        drain();

        // **************************************************
        // Fault and interrupt sequence.
        // **************************************************
        bit_sel = 4 + int'($urandom % 12); // A watched status bit.
        @(posedge clk);
        status[bit_sel] <= 1'b0;
        host_access(5'd1, 1'b0, 16'd0); // INTFLAG.
        host_access(5'd1, 1'b0, 16'd0); // Restored to ones.
        host_access(5'd2, 1'b0, 16'd0);
        host_access(5'd0, 1'b0, 16'd0);
        run_traffic(120); // Commands are zero under fault.
        drain();
        @(posedge clk);
        status <= '1;
        host_access(5'd2, 1'b1, 16'd3); // Set wins over clear.
        host_access(5'd2, 1'b0, 16'd0);
        host_access(5'd2, 1'b1, 16'd2);
        host_access(5'd2, 1'b0, 16'd0);
        host_access(5'd2, 1'b1, 16'd1);
        host_access(5'd2, 1'b1, 16'd2);
        host_access(5'd1, 1'b0, 16'd0);
        repeat (3) @(posedge clk);
        run_traffic(160);
        drain();

        @(negedge clk);
        $display("Errors: checker %0d, testbench %0d", errors, tb_errors);
        if (errors == 0 && tb_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb/motor_control_checker.sv */
// Fault events must occur only while every pipeline is empty, since the PI model integrates at acceptance.
`timescale 1ns/1ps

module motor_control_checker #(
    parameter int gain_scale = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [4:0]                          address,
    input  logic                                read,
    input  logic                                write,
    input  logic [15:0]                         writedata,
    input  logic [15:0]                         readdata,
    input  motor_ctrl_pkg::fault_status_t       status,
    input  logic [3:0]                          pos_error,
    input  logic [3:0]                          pos_uncertain,
    input  logic signed [15:0]                  encoder_count [motor_ctrl_pkg::num_axes],
    input  logic [motor_ctrl_pkg::num_axes-1:0] meas_valid,
    input  logic [motor_ctrl_pkg::num_axes-1:0] meas_ready,
    input  motor_ctrl_pkg::dq_pair_t            meas [motor_ctrl_pkg::num_axes],
    input  logic                                out_valid,
    input  logic                                out_ready,
    input  motor_ctrl_pkg::voltage_cmd_t        out_cmd,
    input  logic                                fault,
    input  logic                                irq,
    output int                                  errors,
    output int                                  pending
);
    import motor_ctrl_pkg::*;

    dq_pair_t     m_ref [num_axes];      // Reference registers.
    dq_pair_t     m_held [num_axes];     // Captured measurements.
    logic [15:0]  m_kp;
    logic [15:0]  m_ki;
    logic [11:0]  m_flags;               // Interrupt flags, active low.
    logic [11:0]  m_prev;                // Watched status bits, one cycle old.
    logic         m_fault;
    logic         m_irq;
    logic         m_set;                 // Pulses from a FAULT write.
    logic         m_clear;
    logic         read_pend;             // Readdata due at the next edge.
    logic [15:0]  exp_read;
    logic         stall_prev;            // Output was stalled last edge.
    voltage_cmd_t out_prev;
    longint       integ_d [num_axes];    // Integrator model per axis.
    longint       integ_q [num_axes];
    dq_pair_t     exp_q [num_axes][$];   // Expected commands per axis, in order.

    task automatic compare_value(input string name, input longint expv, input longint got);
        if (expv != got) begin
            errors++;
            $display("FAILED at %0t: %s expected %0d got %0d", $time, name, expv, got);
        end
    endtask

    // Floor of error times gain over 2**gain_scale.
    function automatic longint gain_term(input longint r, input longint m, input longint g);
        return ((r - m) * g) >>> gain_scale;
    endfunction

    function automatic longint sat16(input longint x);
        if (x > 32767) return 32767;
        if (x < -32768) return -32768;
        return x;
    endfunction

    // Register map readback from the model state.
    function automatic logic [15:0] expected_word(input logic [4:0] a);
        int k;
        k = (int'(a) / 2) % 4; // Axis of a per-axis d/q word.
        if (a == 5'd0) return status;
        if (a == 5'd1) return {m_flags, 4'hf};
        if (a == 5'd2) return {15'd0, m_fault};
        if (a == 5'd3) return {8'd0, pos_error, pos_uncertain};
        if (a >= 5'd4 && a <= 5'd7) return encoder_count[a - 5'd4];
        if (a >= 5'd8 && a <= 5'd15) return a[0] ? m_held[k].q : m_held[k].d;
        if (a >= 5'd16 && a <= 5'd23) return a[0] ? m_ref[k].q : m_ref[k].d;
        if (a == 5'd24) return m_kp;
        if (a == 5'd25) return m_ki;
        return 16'd0; // Unmapped.
    endfunction

    always @(posedge clk) begin
        logic [11:0] watched;
        logic [11:0] falling;
        dq_pair_t    e;
        longint      p_d;
        longint      p_q;
        int          total;
        watched = status[15:4];
        if (reset) begin
            m_kp = '0;
            m_ki = '0;
            m_flags = '1;
            m_prev = '1;
            {m_fault, m_irq, m_set, m_clear, read_pend, stall_prev} = '0;
            for (int a = 0; a < num_axes; a++) begin
                m_ref[a] = '0;
                m_held[a] = '0;
                integ_d[a] = 0;
                integ_q[a] = 0;
                exp_q[a].delete();
            end
        end else begin
            // **************************************************
            // Compare outputs as they stand before this edge.
            // **************************************************
            if (read_pend) compare_value("readdata", exp_read, readdata);
            compare_value("fault", m_fault, fault);
            compare_value("irq", m_irq, irq);
            if (stall_prev) begin
                compare_value("out_valid", 1, out_valid); // Must hold while stalled.
                compare_value("out_cmd", out_prev, out_cmd);
            end
            if (out_valid && out_ready) begin
                if (exp_q[out_cmd.axis].size() == 0) begin
                    errors++;
                    $display("Command for axis %0d arrived with none expected", out_cmd.axis);
                end else begin
                    e = exp_q[out_cmd.axis].pop_front();
                    compare_value("out_cmd.voltage.d", e.d, out_cmd.voltage.d);
                    compare_value("out_cmd.voltage.q", e.q, out_cmd.voltage.q);
                end
            end
            // **************************************************
            // Advance the model by one edge.
            // **************************************************
            read_pend = read;
            if (read) exp_read = expected_word(address);
            falling = m_prev & ~watched & {12{~m_clear}}; // Masked during a clear.
            m_irq = (m_flags != '1);
            m_flags = (m_flags | {12{read && address == 5'd1}}) & ~falling;
            if (watched != '1 || m_set) m_fault = 1'b1;
            else if (m_clear) m_fault = 1'b0;
            m_prev = watched;
            m_set = write && address == 5'd2 && writedata[0];
            m_clear = write && address == 5'd2 && writedata[1];
            for (int a = 0; a < num_axes; a++) begin
                if (fault) begin
                    integ_d[a] = 0; // Integrator held at zero.
                    integ_q[a] = 0;
                end
                if (meas_valid[a] && meas_ready[a]) begin
                    p_d = gain_term(m_ref[a].d, meas[a].d, m_kp);
                    p_q = gain_term(m_ref[a].q, meas[a].q, m_kp);
                    if (!fault) begin
                        integ_d[a] = sat16(integ_d[a] + gain_term(m_ref[a].d, meas[a].d, m_ki));
                        integ_q[a] = sat16(integ_q[a] + gain_term(m_ref[a].q, meas[a].q, m_ki));
                    end
                    e.d = fault ? 16'sd0 : 16'(sat16(p_d + integ_d[a]));
                    e.q = fault ? 16'sd0 : 16'(sat16(p_q + integ_q[a]));
                    exp_q[a].push_back(e);
                    m_held[a] = meas[a];
                end
            end
            if (write && address >= 5'd16 && address <= 5'd23) begin
                if (address[0]) m_ref[address[2:1]].q = writedata;
                else m_ref[address[2:1]].d = writedata;
            end
            if (write && address == 5'd24) m_kp = writedata;
            if (write && address == 5'd25) m_ki = writedata;
            stall_prev = out_valid && !out_ready;
            out_prev = out_cmd;
        end
        total = 0;
        for (int a = 0; a < num_axes; a++) total += exp_q[a].size();
        pending <= total; // Commands accepted but not yet delivered.
    end

endmodule

/* source/motor_control_top.sv */
// Four axes on one clock; modulator, encoders and ADC front end are outside this block.
`timescale 1ns/1ps

module motor_control_top #(
    parameter int gain_scale = 8 // Fractional bits of KP and KI.
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [4:0]                          address,
    input  logic                                read,
    input  logic                                write,
    input  logic [15:0]                         writedata,
    output logic [15:0]                         readdata,
    input  motor_ctrl_pkg::fault_status_t       status,
    input  logic [3:0]                          pos_error,
    input  logic [3:0]                          pos_uncertain,
    input  logic signed [15:0]                  encoder_count [motor_ctrl_pkg::num_axes],
    input  logic [motor_ctrl_pkg::num_axes-1:0] meas_valid,
    output logic [motor_ctrl_pkg::num_axes-1:0] meas_ready,
    input  motor_ctrl_pkg::dq_pair_t            meas [motor_ctrl_pkg::num_axes],
    output logic                                out_valid,
    input  logic                                out_ready,
    output motor_ctrl_pkg::voltage_cmd_t        out_cmd,
    output logic                                fault,
    output logic                                irq
);
    import motor_ctrl_pkg::*;

    logic                fault_set;    // Pulses from the FAULT register.
    logic                fault_clear;
    logic                intflag_read; // INTFLAG read strobe.
    logic [11:0]         intflags;
    dq_pair_t            ref_dq [num_axes];
    logic [15:0]         kp;
    logic [15:0]         ki;
    logic [num_axes-1:0] cmd_valid;
    logic [num_axes-1:0] cmd_ready;
    dq_pair_t            cmd [num_axes];

    // Port names match the nets here.
    control_registers u_regs (.*);

    fault_monitor u_fault (.*);

    for (genvar a = 0; a < num_axes; a++) begin : g_axis
        current_pi_controller #(
            .gain_scale(gain_scale)
        ) u_pi (
            .clk       (clk),
            .reset     (reset),
            .meas_valid(meas_valid[a]),
            .meas_ready(meas_ready[a]),
            .meas      (meas[a]),
            .ref_dq    (ref_dq[a]),
            .kp        (kp),
            .ki        (ki),
            .fault     (fault),
            .cmd_valid (cmd_valid[a]),
            .cmd_ready (cmd_ready[a]),
            .cmd       (cmd[a])
        );
    end

    voltage_arbiter u_arb (.*);

endmodule

/* source/voltage_arbiter.sv */
// Single output register; an axis waits at most three grants behind the others.
`timescale 1ns/1ps

module voltage_arbiter (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [motor_ctrl_pkg::num_axes-1:0] cmd_valid,
    output logic [motor_ctrl_pkg::num_axes-1:0] cmd_ready,
    input  motor_ctrl_pkg::dq_pair_t            cmd [motor_ctrl_pkg::num_axes],
    output logic                                out_valid,
    input  logic                                out_ready,
    output motor_ctrl_pkg::voltage_cmd_t        out_cmd
);
    import motor_ctrl_pkg::*;

    logic [1:0] last_grant; // Most recent winner.
    logic [1:0] scan;       // Candidate during the search.
    logic [1:0] pick;       // Winner this cycle.
    logic       found;      // Some axis requests.
    logic       free;       // Output register empty or draining.

    assign free = !out_valid || out_ready; // Refill in the draining cycle.

    // Search starts just after the last winner.
    always_comb begin
        pick  = last_grant;
        found = 1'b0;
        for (int i = 1; i <= num_axes; i++) begin
            scan = last_grant + 2'(i);
            if (!found && cmd_valid[scan]) begin
                pick  = scan;
                found = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_axes; i++) begin
            cmd_ready[i] = free && found && (pick == 2'(i));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            last_grant <= '0;
        end else if (free) begin
            out_valid <= found;
            if (found) begin
                last_grant <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (free && found) begin
            out_cmd.axis    <= pick;
            out_cmd.voltage <= cmd[pick];
        end
    end

    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_cmd));

endmodule

/* source/current_pi_controller.sv */
// Gains are unsigned with gain_scale fractional bits; commands and integrator saturate to 16 bits.
`timescale 1ns/1ps

module current_pi_controller #(
    parameter int gain_scale = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     meas_valid,
    output logic                     meas_ready,
    input  motor_ctrl_pkg::dq_pair_t meas,
    input  motor_ctrl_pkg::dq_pair_t ref_dq,
    input  logic [15:0]              kp,
    input  logic [15:0]              ki,
    input  logic                     fault,
    output logic                     cmd_valid,
    input  logic                     cmd_ready,
    output motor_ctrl_pkg::dq_pair_t cmd
);

    logic               s1_valid;     // Stage one holds terms.
    logic               s2_free;      // Output register can load.
    logic               s1_adv;       // Stage one moves to stage two.
    logic signed [33:0] p_term_d;     // Kp times error, scaled.
    logic signed [33:0] p_term_q;
    logic signed [33:0] i_term_d;     // Ki times error, scaled.
    logic signed [33:0] i_term_q;
    logic signed [31:0] integ_d;      // Integrators, kept inside 16-bit range.
    logic signed [31:0] integ_q;
    logic signed [15:0] integ_next_d;
    logic signed [15:0] integ_next_q;

    // Error times gain, arithmetic shift drops the fraction.
    function automatic logic signed [33:0] scaled(input logic signed [15:0] ref_v,
                                                 input logic signed [15:0] meas_v,
                                                 input logic [15:0]        gain);
        logic signed [16:0] err;
        logic signed [33:0] prod;
        err  = ref_v - meas_v;
        prod = err * $signed({1'b0, gain});
        return prod >>> gain_scale;
    endfunction

    function automatic logic signed [15:0] sat16(input logic signed [35:0] x);
        if (x > 36'sd32767) begin
            return 16'sh7fff;
        end else if (x < -36'sd32768) begin
            return 16'sh8000;
        end
        return x[15:0];
    endfunction

    assign s2_free    = !cmd_valid || cmd_ready;
    assign s1_adv     = s1_valid && s2_free;
    assign meas_ready = !s1_valid || s2_free; // Low only when stage one is stuck.

    assign integ_next_d = sat16(36'(integ_d) + 36'(i_term_d));
    assign integ_next_q = sat16(36'(integ_q) + 36'(i_term_q));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            cmd_valid <= 1'b0;
            integ_d   <= '0;
            integ_q   <= '0;
        end else begin
            if (meas_ready) begin
                s1_valid <= meas_valid;
            end
            if (s2_free) begin
                cmd_valid <= s1_valid;
            end
            if (fault) begin
                integ_d <= '0; // Integrators held at zero under fault.
                integ_q <= '0;
            end else if (s1_adv) begin
                integ_d <= 32'(integ_next_d);
                integ_q <= 32'(integ_next_q);
            end
        end
    end

    // **************************************************
    // Datapath, no reset needed.
    // **************************************************
    always_ff @(posedge clk) begin
        if (meas_valid && meas_ready) begin // References and gains sampled here.
            p_term_d <= scaled(ref_dq.d, meas.d, kp);
            p_term_q <= scaled(ref_dq.q, meas.q, kp);
            i_term_d <= scaled(ref_dq.d, meas.d, ki);
            i_term_q <= scaled(ref_dq.q, meas.q, ki);
        end
        if (s1_adv) begin
            cmd.d <= fault ? 16'sd0 : sat16(36'(p_term_d) + 36'(integ_next_d));
            cmd.q <= fault ? 16'sd0 : sat16(36'(p_term_q) + 36'(integ_next_q));
        end
    end

    cmd_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

/* source/control_registers.sv */
// No wait states: read data is valid the cycle after the strobe, read and write never together.
`timescale 1ns/1ps

module control_registers (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [4:0]                          address,
    input  logic                                read,
    input  logic                                write,
    input  logic [15:0]                         writedata,
    output logic [15:0]                         readdata,
    input  motor_ctrl_pkg::fault_status_t       status,
    input  logic [3:0]                          pos_error,
    input  logic [3:0]                          pos_uncertain,
    input  logic signed [15:0]                  encoder_count [motor_ctrl_pkg::num_axes],
    input  logic [motor_ctrl_pkg::num_axes-1:0] meas_valid,
    input  logic [motor_ctrl_pkg::num_axes-1:0] meas_ready,
    input  motor_ctrl_pkg::dq_pair_t            meas [motor_ctrl_pkg::num_axes],
    input  logic                                fault,
    input  logic [11:0]                         intflags,
    output logic                                fault_set,
    output logic                                fault_clear,
    output logic                                intflag_read,
    output motor_ctrl_pkg::dq_pair_t            ref_dq [motor_ctrl_pkg::num_axes],
    output logic [15:0]                         kp,
    output logic [15:0]                         ki
);
    import motor_ctrl_pkg::*;

    dq_pair_t    meas_held [num_axes]; // Last accepted measurement per axis.
    logic [15:0] read_word;            // Read mux.

    // **************************************************
    // Readback decode.
    // **************************************************
    // Per-axis words: address[2:1] is the axis, address[0] selects q.
    always_comb begin
        read_word = '0; // Unmapped reads return 0.
        case (address) inside
            addr_status:   read_word = status;
            addr_intflag:  read_word = {intflags, 4'hf}; // Reserved nibble reads as ones.
            addr_fault:    read_word = {15'd0, fault};
            addr_position: read_word = {8'd0, pos_error, pos_uncertain};
            [addr_encoder1:addr_encoder4]: begin
                read_word = encoder_count[address[1:0]];
            end
            [addr_imeasd1:addr_imeasq4]: begin
                read_word = address[0] ? meas_held[address[2:1]].q : meas_held[address[2:1]].d;
            end
            [addr_irefd1:addr_irefq4]: begin
                read_word = address[0] ? ref_dq[address[2:1]].q : ref_dq[address[2:1]].d;
            end
            addr_kp:       read_word = kp;
            addr_ki:       read_word = ki;
            default: ;
        endcase
    end

    // Flags restore at the same edge that samples them.
    assign intflag_read = read && (address == addr_intflag);

    // **************************************************
    // Register storage and strobes.
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readdata    <= '0;
            fault_set   <= 1'b0;
            fault_clear <= 1'b0;
            kp          <= '0;
            ki          <= '0;
            for (int i = 0; i < num_axes; i++) begin
                ref_dq[i]    <= '0;
                meas_held[i] <= '0;
            end
        end else begin
            if (read) begin
                readdata <= read_word; // Holds until the next read.
            end
            // One-cycle pulses toward the fault monitor.
            fault_set   <= write && (address == addr_fault) && writedata[0];
            fault_clear <= write && (address == addr_fault) && writedata[1];
            if (write) begin
                case (address) inside
                    addr_kp: kp <= writedata;
                    addr_ki: ki <= writedata;
                    [addr_irefd1:addr_irefq4]: begin
                        if (address[0]) begin
                            ref_dq[address[2:1]].q <= writedata;
                        end else begin
                            ref_dq[address[2:1]].d <= writedata;
                        end
                    end
                    default: ;
                endcase
            end
            for (int i = 0; i < num_axes; i++) begin
                if (meas_valid[i] && meas_ready[i]) begin
                    meas_held[i] <= meas[i]; // Capture on transfer.
                end
            end
        end
    end

    host_strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

endmodule

/* source/fault_monitor.sv */
// Encoder faults are shown in STATUS only; they neither latch the fault nor raise a flag.
`timescale 1ns/1ps

module fault_monitor (
    input  logic                          clk,
    input  logic                          reset,
    input  motor_ctrl_pkg::fault_status_t status,
    input  logic                          fault_set,
    input  logic                          fault_clear,
    input  logic                          intflag_read,
    output logic                          fault,
    output logic                          irq,
    output logic [11:0]                   intflags
);

    logic [11:0] watched;      // Driver OTW, driver fault and Hall bits.
    logic [11:0] watched_prev; // Same bits, one cycle old.
    logic [11:0] falling;      // 1 to 0 transitions this cycle.

    assign watched = {status.driver_otw_n, status.driver_fault_n, status.hall_fault_n};

    // Edge detectors are blind during a clear pulse.
    assign falling = watched_prev & ~watched & {12{~fault_clear}};

    // **************************************************
    // Flags, irq and fault latch.
    // **************************************************
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            watched_prev <= '1; // Idle state is no fault.
            intflags     <= '1;
            irq          <= 1'b0;
            fault        <= 1'b0;
        end else begin
            watched_prev <= watched;
            // A read restores all ones, but a new edge still clears its bit.
            intflags <= (intflags | {12{intflag_read}}) & ~falling;
            irq      <= ~&intflags; // Any flag at 0.
            if (~&watched) begin
                fault <= 1'b1;      // Condition present.
            end else if (fault_set) begin
                fault <= 1'b1;      // Set wins over clear.
            end else if (fault_clear) begin
                fault <= 1'b0;
            end
        end
    end

    // irq rises only after a watched status bit went low.
    irq_from_status: assert property (@(posedge clk) disable iff (reset)
        $rose(irq) |-> $past(~&watched, 2));

endmodule

/* source/motor_ctrl_pkg.sv */
// Axis count is fixed at four by the register map; all current words are signed 16-bit.
package motor_ctrl_pkg;

    localparam int num_axes = 4; // Set by the register map.

    // Host word addresses, in register map order.
    typedef enum logic [4:0] {
        addr_status   = 5'h00,
        addr_intflag  = 5'h01,
        addr_fault    = 5'h02,
        addr_position = 5'h03,
        addr_encoder1 = 5'h04,
        addr_encoder2 = 5'h05,
        addr_encoder3 = 5'h06,
        addr_encoder4 = 5'h07,
        addr_imeasd1  = 5'h08,
        addr_imeasq1  = 5'h09,
        addr_imeasd2  = 5'h0a,
        addr_imeasq2  = 5'h0b,
        addr_imeasd3  = 5'h0c,
        addr_imeasq3  = 5'h0d,
        addr_imeasd4  = 5'h0e,
        addr_imeasq4  = 5'h0f,
        addr_irefd1   = 5'h10,
        addr_irefq1   = 5'h11,
        addr_irefd2   = 5'h12,
        addr_irefq2   = 5'h13,
        addr_irefd3   = 5'h14,
        addr_irefq3   = 5'h15,
        addr_irefd4   = 5'h16,
        addr_irefq4   = 5'h17,
        addr_kp       = 5'h18,
        addr_ki       = 5'h19
    } reg_addr_e;

    typedef struct packed {
        logic signed [15:0] d; // Direct axis.
        logic signed [15:0] q; // Quadrature axis.
    } dq_pair_t;

    typedef struct packed {
        logic [1:0] axis;    // Source axis, 0 to 3.
        dq_pair_t   voltage; // Voltage command for that axis.
    } voltage_cmd_t;

    // All bits active low, bit n is axis n+1.
    typedef struct packed {
        logic [3:0] driver_otw_n;
        logic [3:0] driver_fault_n;
        logic [3:0] hall_fault_n;
        logic [3:0] encoder_fault_n;
    } fault_status_t;

endpackage
